// File: common/scsi_sm_pkg.sv
// scsi state machine tables
package scsi_sm_pkg;

  localparam int num_terms = 28;            // product terms in the and plane

  typedef logic [num_terms-1:0] term_vec_t; // active low, bit i is E_[i]

  typedef enum logic [4:0] {
    st_idle       = 5'd0,
    st_cpu_rd     = 5'd1,
    st_cpu_wr     = 5'd2,
    st_dma_in     = 5'd3,
    st_dma_in_wr  = 5'd4,
    st_dma_out    = 5'd5,
    st_dma_out_rd = 5'd6,
    st_done       = 5'd7
  } sm_state_t;

  typedef enum logic [3:0] {
    c_cpu_rd,      // cpu read request
    c_cpu_wr,      // cpu write request
    c_dreq_in,     // dma request, scsi to fifo, no cpu request
    c_dreq_out,    // dma request, fifo to scsi, no cpu request
    c_not_last,
    c_last,        // byte pointer on lane 3
    c_not_full,    // dreq still high and room left
    c_not_empty,   // dreq still high and data left
    c_always
  } cond_t;

  // spare terms sit on a code the state register never holds
  localparam sm_state_t st_spare = sm_state_t'(5'h1f);

  localparam sm_state_t term_state [num_terms] = '{
    0: st_idle,        1: st_idle,       17: st_idle,       18: st_idle,
    3: st_dma_out_rd, 11: st_dma_out_rd,  4: st_dma_in_wr,  10: st_dma_in_wr,
    5: st_done,        7: st_dma_in,      9: st_dma_out,
    22: st_cpu_wr,    25: st_cpu_rd,
    default: st_spare
  };

  localparam cond_t term_cond [num_terms] = '{
    0: c_dreq_in,      1: c_dreq_out,    17: c_cpu_rd,      18: c_cpu_wr,
    3: c_last,        11: c_not_last,     4: c_last,        10: c_not_last,
    7: c_not_full,     9: c_not_empty,
    default: c_always
  };

  // or plane groups
  localparam term_vec_t mask_dack      = 28'h0000c18; // 3 4 10 11
  localparam term_vec_t mask_incbo     = 28'h0000c18; // 3 4 10 11
  localparam term_vec_t mask_incni     = 28'h0000010; // 4
  localparam term_vec_t mask_incno     = 28'h0000008; // 3
  localparam term_vec_t mask_re        = 28'h0020410; // 4 10 17
  localparam term_vec_t mask_we        = 28'h0040808; // 3 11 18
  localparam term_vec_t mask_scsi_cs   = 28'h0060000; // 17 18
  localparam term_vec_t mask_set_dsack = 28'h2400000; // 22 25
  localparam term_vec_t mask_s2f       = 28'h0000410; // 4 10
  localparam term_vec_t mask_f2s       = 28'h0000808; // 3 11
  localparam term_vec_t mask_s2cpu     = 28'h2000000; // 25
  localparam term_vec_t mask_cpu2s     = 28'h0400000; // 22

  // next state, one mask per bit, bit 0 first
  localparam term_vec_t mask_ns [5] = '{
    28'h0020c1b,   // 0 1 3 4 10 11 17
    28'h0040619,   // 0 3 4 9 10 18
    28'h0000a9a,   // 1 3 4 7 9 11
    28'h0000000,
    28'h0000000
  };

endpackage

// File: common/fifo_pkg.sv
// byte packing fifo types
package fifo_pkg;

  localparam int fifo_depth = 8;      // 32 bit words
  localparam int ptr_bits   = $clog2(fifo_depth);

  typedef logic [31:0]         fifo_word_t;
  typedef logic [7:0]          fifo_byte_t;
  typedef logic [ptr_bits-1:0] fifo_ptr_t;  // word index, wrap bit kept apart
  typedef logic [1:0]          byte_ptr_t;  // lane in word

endpackage

// File: scsi_sm/scsi_sm_inputs.sv
// scsi sm and plane
module scsi_sm_inputs (
  input  scsi_sm_pkg::sm_state_t state,
  input  logic                   cpureq,
  input  logic                   cpu_rd,
  input  logic                   dreq,
  input  logic                   dma_dir,    // 1 = scsi to fifo
  input  logic                   bo_last,
  input  logic                   fifo_full,
  input  logic                   fifo_empty,
  output scsi_sm_pkg::term_vec_t e_n
);

  import scsi_sm_pkg::*;

  logic [c_always:0] cond_hit;   // one bit per condition code

  // each condition evaluated once, terms just pick one
  always_comb begin
    cond_hit              = '0;
    cond_hit[c_cpu_rd]    = cpureq & cpu_rd;
    cond_hit[c_cpu_wr]    = cpureq & ~cpu_rd;
    cond_hit[c_dreq_in]   = ~cpureq & dreq & dma_dir;   // cpu wins over dma
    cond_hit[c_dreq_out]  = ~cpureq & dreq & ~dma_dir;
    cond_hit[c_not_last]  = ~bo_last;
    cond_hit[c_last]      = bo_last;
    cond_hit[c_not_full]  = dreq & ~fifo_full;          // stall while full
    cond_hit[c_not_empty] = dreq & ~fifo_empty;         // stall while empty
    cond_hit[c_always]    = 1'b1;
  end

  // term low when state matches and its condition holds
  always_comb begin
    for (int i = 0; i < num_terms; i++) begin
      e_n[i] = ~((state == term_state[i]) && cond_hit[term_cond[i]]);
    end
  end

endmodule

// File: scsi_sm/scsi_sm_outputs.sv
// scsi sm or plane
module scsi_sm_outputs (
  input  scsi_sm_pkg::term_vec_t e_n,
  output logic                   dack,
  output logic                   incbo,
  output logic                   incni,
  output logic                   incno,
  output logic                   re,
  output logic                   we,
  output logic                   scsi_cs,
  output logic                   set_dsack,
  output logic                   s2f,
  output logic                   f2s,
  output logic                   s2cpu,
  output logic                   cpu2s,
  output scsi_sm_pkg::sm_state_t next_state
);

  import scsi_sm_pkg::*;

  term_vec_t  e_act;     // active high copy of the terms
  logic [4:0] ns_bits;

  assign e_act = ~e_n;

  // strobes, any term of the group
  assign dack      = |(e_act & mask_dack);
  assign incbo     = |(e_act & mask_incbo);
  assign incni     = |(e_act & mask_incni);   // word done on scsi side
  assign incno     = |(e_act & mask_incno);
  assign re        = |(e_act & mask_re);
  assign we        = |(e_act & mask_we);
  assign scsi_cs   = |(e_act & mask_scsi_cs);
  assign set_dsack = |(e_act & mask_set_dsack);
  assign s2f       = |(e_act & mask_s2f);
  assign f2s       = |(e_act & mask_f2s);
  assign s2cpu     = |(e_act & mask_s2cpu);
  assign cpu2s     = |(e_act & mask_cpu2s);

  // next state bits, no term active gives idle
  always_comb begin
    for (int b = 0; b < 5; b++) begin
      ns_bits[b] = |(e_act & mask_ns[b]);
    end
  end

  assign next_state = sm_state_t'(ns_bits);

endmodule

// File: scsi_sm/scsi_sm.sv
// scsi state machine
module scsi_sm (
  input  logic clk,
  input  logic arst_n,
  input  logic cpureq,
  input  logic cpu_rd,
  input  logic dreq,
  input  logic dma_dir,
  input  logic bo_last,
  input  logic fifo_full,
  input  logic fifo_empty,
  output logic dack,
  output logic incbo,
  output logic incni,
  output logic incno,
  output logic re,
  output logic we,
  output logic scsi_cs,
  output logic set_dsack,
  output logic s2f,
  output logic f2s,
  output logic s2cpu,
  output logic cpu2s
);

  import scsi_sm_pkg::*;

  sm_state_t state;
  sm_state_t next_state;
  term_vec_t e_n;

  scsi_sm_inputs u_inputs (
    .state      (state),
    .cpureq     (cpureq),
    .cpu_rd     (cpu_rd),
    .dreq       (dreq),
    .dma_dir    (dma_dir),
    .bo_last    (bo_last),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .e_n        (e_n)
  );

  scsi_sm_outputs u_outputs (
    .e_n        (e_n),
    .dack       (dack),
    .incbo      (incbo),
    .incni      (incni),
    .incno      (incno),
    .re         (re),
    .we         (we),
    .scsi_cs    (scsi_cs),
    .set_dsack  (set_dsack),
    .s2f        (s2f),
    .f2s        (f2s),
    .s2cpu      (s2cpu),
    .cpu2s      (cpu2s),
    .next_state (next_state)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) state <= st_idle;
    else         state <= next_state;   // loads every edge
  end

  // table must keep terms exclusive across both planes
  a_one_term: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(~e_n));
  // never land on the spare code or on an unknown one
  a_ns_valid: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(next_state) && (next_state inside {[st_idle:st_done]}));
  a_dir_excl: assert property (@(posedge clk) disable iff (!arst_n) !(s2f && f2s));

endmodule

// File: verilog/fifo_ctrl.sv
// byte packing fifo
module fifo_ctrl (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                s2f,        // write byte into lane bo
  input  logic                f2s,        // read byte from lane bo
  input  logic                incbo,
  input  logic                incni,
  input  logic                incno,
  input  fifo_pkg::fifo_byte_t scsi_din,
  output fifo_pkg::fifo_byte_t scsi_dout,
  output fifo_pkg::fifo_word_t fifo_rdata,
  output logic                bo_last,
  output logic                fifo_full,
  output logic                fifo_empty
);

  import fifo_pkg::*;

  fifo_word_t mem [fifo_depth];
  byte_ptr_t  bo;           // shared byte lane pointer
  fifo_ptr_t  in_ptr;
  fifo_ptr_t  out_ptr;
  logic       in_wrap;
  logic       out_wrap;

  // byte lane write, no reset on storage
  always_ff @(posedge clk) begin
    if (s2f) mem[in_ptr][bo*8 +: 8] <= scsi_din;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bo <= '0;
    end else if (incbo) begin
      bo <= bo + 2'd1;      // wraps 3 to 0
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_ptr  <= '0;
      in_wrap <= 1'b0;
    end else if (incni) begin
      {in_wrap, in_ptr} <= {in_wrap, in_ptr} + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_ptr  <= '0;
      out_wrap <= 1'b0;
    end else if (incno) begin
      {out_wrap, out_ptr} <= {out_wrap, out_ptr} + 1'b1;
    end
  end

  assign bo_last    = (bo == 2'd3);
  assign fifo_rdata = mem[out_ptr];
  assign scsi_dout  = f2s ? fifo_rdata[bo*8 +: 8] : '0;  // quiet when idle

  // same index, wrap bit tells full from empty
  assign fifo_full  = (in_ptr == out_ptr) && (in_wrap != out_wrap);
  assign fifo_empty = (in_ptr == out_ptr) && (in_wrap == out_wrap);

  // decoder stalls on the flags, so pointers never overrun
  a_no_ovf: assert property (@(posedge clk) disable iff (!arst_n) !(incni && fifo_full));
  a_no_unf: assert property (@(posedge clk) disable iff (!arst_n) !(incno && fifo_empty));

endmodule

// File: verilog/scsi_dma_top.sv
// scsi dma top
module scsi_dma_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cpureq,
  input  logic                 cpu_rd,
  input  logic                 dreq,
  input  logic                 dma_dir,
  input  fifo_pkg::fifo_byte_t scsi_din,
  output logic                 dack,
  output logic                 re,
  output logic                 we,
  output logic                 scsi_cs,
  output logic                 set_dsack,
  output logic                 s2cpu,
  output logic                 cpu2s,
  output fifo_pkg::fifo_byte_t scsi_dout,
  output fifo_pkg::fifo_word_t fifo_rdata,
  output logic                 fifo_empty
);

  // sm to fifo strobes
  logic incbo, incni, incno;
  logic s2f, f2s;
  // fifo flags back to the decoder
  logic bo_last, fifo_full;

  scsi_sm u_scsi_sm (
    .clk        (clk),
    .arst_n     (arst_n),
    .cpureq     (cpureq),
    .cpu_rd     (cpu_rd),
    .dreq       (dreq),
    .dma_dir    (dma_dir),
    .bo_last    (bo_last),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .dack       (dack),
    .incbo      (incbo),
    .incni      (incni),
    .incno      (incno),
    .re         (re),
    .we         (we),
    .scsi_cs    (scsi_cs),
    .set_dsack  (set_dsack),
    .s2f        (s2f),
    .f2s        (f2s),
    .s2cpu      (s2cpu),
    .cpu2s      (cpu2s)
  );

  fifo_ctrl u_fifo_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .s2f        (s2f),
    .f2s        (f2s),
    .incbo      (incbo),
    .incni      (incni),
    .incno      (incno),
    .scsi_din   (scsi_din),
    .scsi_dout  (scsi_dout),
    .fifo_rdata (fifo_rdata),
    .bo_last    (bo_last),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

endmodule

// File: bench/tb_clkgen.sv
// testbench clock and reset
module tb_clkgen (
  output logic clk,
  output logic arst_n
);

  localparam int half_period  = 2;    // period 4
  localparam int reset_cycles = 10;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;                    // released away from the rising edge
  end

endmodule

// File: bench/tb_scsi_dma.sv
// scsi dma testbench
module tb_scsi_dma;

  import scsi_sm_pkg::*;

  localparam int clk_period = 4;
  localparam int max_rows   = 320;
  localparam int num_random = 200;

  typedef struct packed {
    logic        cpureq;
    logic        cpu_rd;
    logic        dreq;
    logic        dma_dir;
    logic [7:0]  din;
    logic [2:0]  test;
    logic [6:0]  exp_strb;     // dack re we scsi_cs set_dsack s2cpu cpu2s
    logic [7:0]  exp_dout;
    logic [7:0]  dout_mask;    // zero where the lane holds nothing known
    logic [31:0] exp_rdata;
    logic [31:0] rdata_mask;
    logic        exp_empty;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        cpureq;
  logic        cpu_rd;
  logic        dreq;
  logic        dma_dir;
  logic [7:0]  scsi_din;
  logic        dack;
  logic        re;
  logic        we;
  logic        scsi_cs;
  logic        set_dsack;
  logic        s2cpu;
  logic        cpu2s;
  logic [7:0]  scsi_dout;
  logic [31:0] fifo_rdata;
  logic        fifo_empty;

  row_t  rows [max_rows];
  int    n_rows;
  int    n_checks;
  int    n_errors;
  logic  table_ready;
  string test_name [6] = '{"reset quiet", "cpu access", "dma in", "dma out",
                           "empty stall", "random"};

  // reference model
  sm_state_t  m_state;
  int         m_bo;                  // shared byte lane
  int         m_in;                  // word index with wrap, mod 16
  int         m_out;
  logic [7:0] m_mem [8][4];
  logic       m_wr  [8][4];          // lane written at least once

  tb_clkgen u_clkgen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  scsi_dma_top u_scsi_dma_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .cpureq     (cpureq),
    .cpu_rd     (cpu_rd),
    .dreq       (dreq),
    .dma_dir    (dma_dir),
    .scsi_din   (scsi_din),
    .dack       (dack),
    .re         (re),
    .we         (we),
    .scsi_cs    (scsi_cs),
    .set_dsack  (set_dsack),
    .s2cpu      (s2cpu),
    .cpu2s      (cpu2s),
    .scsi_dout  (scsi_dout),
    .fifo_rdata (fifo_rdata),
    .fifo_empty (fifo_empty)
  );

  task automatic add_row(input logic req, input logic rd, input logic dr, input logic dir,
                         input logic [7:0] din, input int test);
    row_t r;
    r         = '0;
    r.cpureq  = req;
    r.cpu_rd  = rd;
    r.dreq    = dr;
    r.dma_dir = dir;
    r.din     = din;
    r.test    = 3'(test);
    if (n_rows < max_rows) begin
      rows[n_rows] = r;
      n_rows++;
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    repeat (3) add_row(0, 0, 0, 0, 8'h00, 0);
    add_row(1, 1, 0, 0, 8'h00, 1);                // cpu read, two cycles
    repeat (2) add_row(0, 0, 0, 0, 8'h00, 1);
    add_row(1, 0, 0, 0, 8'h00, 1);                // cpu write
    repeat (2) add_row(0, 0, 0, 0, 8'h00, 1);
    // two words in, ten cycles per word
    for (int k = 0; k < 20; k++) add_row(0, 0, 1, 1, 8'(8'h31 + k * 7), 2);
    add_row(0, 0, 0, 1, 8'h00, 2);
    for (int k = 0; k < 20; k++) add_row(0, 0, 1, 0, 8'h00, 3);
    repeat (2) add_row(0, 0, 0, 0, 8'h00, 3);
    repeat (12) add_row(0, 0, 1, 0, 8'h00, 4);    // nothing left to send
    for (int k = 0; k < num_random; k++) begin
      rnd = $urandom;
      add_row(rnd[2:0] == 3'd0, rnd[3], rnd[5:4] != 2'd0, rnd[6], rnd[15:8], 5);
    end
  endtask

  // walks the table once, expected columns from the machine and fifo rules
  task automatic fill_expected();
    logic dack_e, re_e, we_e, cs_e, dsack_e, s2cpu_e, cpu2s_e;
    logic s2f_e, f2s_e, incbo_e, incni_e, incno_e;
    logic full;
    logic empty;
    logic [31:0] rd_e;
    logic [31:0] rd_m;
    sm_state_t ns;
    int wi;
    int wo;
    m_state = st_idle;
    m_bo    = 0;
    m_in    = 0;
    m_out   = 0;
    for (int w = 0; w < 8; w++) begin
      for (int l = 0; l < 4; l++) begin
        m_mem[w][l] = 8'h00;
        m_wr[w][l]  = 1'b0;
      end
    end
    for (int i = 0; i < n_rows; i++) begin
      {dack_e, re_e, we_e, cs_e, dsack_e, s2cpu_e, cpu2s_e} = '0;
      {s2f_e, f2s_e, incbo_e, incni_e, incno_e} = '0;
      wi    = m_in % 8;
      wo    = m_out % 8;
      empty = (m_in == m_out);
      full  = (m_in != m_out) && (wi == wo);   // same slot, other lap
      ns    = st_idle;                          // no active term falls back here
      case (m_state)
        st_idle: begin
          if (rows[i].cpureq) begin             // cpu beats dma
            cs_e = 1'b1;
            re_e = rows[i].cpu_rd;
            we_e = !rows[i].cpu_rd;
            ns   = rows[i].cpu_rd ? st_cpu_rd : st_cpu_wr;
          end else if (rows[i].dreq) begin
            ns = rows[i].dma_dir ? st_dma_in : st_dma_out;
          end
        end
        st_cpu_rd: begin
          dsack_e = 1'b1;
          s2cpu_e = 1'b1;
        end
        st_cpu_wr: begin
          dsack_e = 1'b1;
          cpu2s_e = 1'b1;
        end
        st_dma_in: if (rows[i].dreq && !full) ns = st_dma_in_wr;
        st_dma_in_wr: begin
          dack_e  = 1'b1;
          re_e    = 1'b1;
          s2f_e   = 1'b1;
          incbo_e = 1'b1;
          incni_e = (m_bo == 3);                // word complete
          ns      = (m_bo == 3) ? st_done : st_dma_in;
        end
        st_dma_out: if (rows[i].dreq && !empty) ns = st_dma_out_rd;
        st_dma_out_rd: begin
          dack_e  = 1'b1;
          we_e    = 1'b1;
          f2s_e   = 1'b1;
          incbo_e = 1'b1;
          incno_e = (m_bo == 3);
          ns      = (m_bo == 3) ? st_done : st_dma_out;
        end
        default: ns = st_idle;                  // done
      endcase
      for (int l = 0; l < 4; l++) begin
        rd_e[l*8 +: 8] = m_mem[wo][l];
        rd_m[l*8 +: 8] = m_wr[wo][l] ? 8'hff : 8'h00;
      end
      rows[i].exp_strb   = {dack_e, re_e, we_e, cs_e, dsack_e, s2cpu_e, cpu2s_e};
      rows[i].exp_empty  = empty;
      rows[i].exp_rdata  = rd_e;
      rows[i].rdata_mask = rd_m;
      rows[i].exp_dout   = f2s_e ? m_mem[wo][m_bo] : 8'h00;
      rows[i].dout_mask  = (f2s_e && !m_wr[wo][m_bo]) ? 8'h00 : 8'hff;
      // clock edge
      if (s2f_e) begin
        m_mem[wi][m_bo] = rows[i].din;
        m_wr[wi][m_bo]  = 1'b1;
      end
      if (incbo_e) m_bo = (m_bo + 1) % 4;
      if (incni_e) m_in = (m_in + 1) % 16;
      if (incno_e) m_out = (m_out + 1) % 16;
      m_state = ns;
    end
  endtask

  task automatic check_row(input int i);
    logic [6:0] got_strb;
    got_strb = {dack, re, we, scsi_cs, set_dsack, s2cpu, cpu2s};
    n_checks += 4;
    if (got_strb !== rows[i].exp_strb) begin
      $display("FAIL %0t: row %0d strobes got %b expected %b", $time, i, got_strb,
               rows[i].exp_strb);
      n_errors++;
    end
    if ((scsi_dout & rows[i].dout_mask) !== (rows[i].exp_dout & rows[i].dout_mask)) begin
      $display("FAIL %0t: row %0d scsi_dout got %h expected %h", $time, i, scsi_dout,
               rows[i].exp_dout);
      n_errors++;
    end
    if (fifo_empty !== rows[i].exp_empty) begin
      $display("FAIL %0t: row %0d fifo_empty got %b expected %b", $time, i, fifo_empty,
               rows[i].exp_empty);
      n_errors++;
    end
    if ((fifo_rdata & rows[i].rdata_mask) !== (rows[i].exp_rdata & rows[i].rdata_mask)) begin
      $display("FAIL %0t: row %0d fifo_rdata got %h expected %h", $time, i, fifo_rdata,
               rows[i].exp_rdata);
      n_errors++;
    end
  endtask

  initial begin
    int seed_val;
    int err_mark;
    cpureq      = 1'b0;
    cpu_rd      = 1'b0;
    dreq        = 1'b0;
    dma_dir     = 1'b0;
    scsi_din    = 8'h00;
    n_rows      = 0;
    n_checks    = 0;
    n_errors    = 0;
    table_ready = 1'b0;
    seed_val    = $urandom(92);                 // one seed for the whole run
    build_table();
    fill_expected();
    table_ready = 1'b1;
    wait (arst_n === 1'b1);
    err_mark = 0;
    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk);
      cpureq   = rows[i].cpureq;
      cpu_rd   = rows[i].cpu_rd;
      dreq     = rows[i].dreq;
      dma_dir  = rows[i].dma_dir;
      scsi_din = rows[i].din;
      #1;                                       // settled, well before the rising edge
      check_row(i);
      if (i == n_rows - 1 || rows[i+1].test != rows[i].test) begin
        $display("test %0d %s: %0d errors", rows[i].test, test_name[rows[i].test],
                 n_errors - err_mark);
        err_mark = n_errors;
      end
    end
    $display("rows %0d, checks %0d, errors %0d", n_rows, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog, four periods per row
  initial begin
    wait (table_ready === 1'b1);
    #(n_rows * clk_period * 4);
    $display("timeout: the table did not finish within %0d time units",
             n_rows * clk_period * 4);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: all.f
common/scsi_sm_pkg.sv
common/fifo_pkg.sv
scsi_sm/scsi_sm_inputs.sv
scsi_sm/scsi_sm_outputs.sv
scsi_sm/scsi_sm.sv
verilog/fifo_ctrl.sv
verilog/scsi_dma_top.sv
bench/tb_clkgen.sv
bench/tb_scsi_dma.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_scsi_dma
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation reported success"; \
	else \
	  echo "no result found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
